// ==== source/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data and address width
`define CORE_XLEN 32

// unified memory depth in 32-bit words
`define CORE_MEM_WORDS 256

// architectural registers, x0 included
`define CORE_REG_COUNT 32

// address of the first instruction after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

// ==== source/core_pkg.sv ====
`default_nettype none

package core_pkg;

    // one-hot stage, idle is the all-zero state after reset
    typedef enum logic [5:0] {
        stage_idle       = 6'b000000,
        stage_fetch      = 6'b000001,
        stage_decode     = 6'b000010,
        stage_read       = 6'b000100,
        stage_execute    = 6'b001000,
        stage_memory     = 6'b010000,
        stage_write_back = 6'b100000
    } stage_e;

    // the compare operations only drive branch_taken
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_eq,
        alu_ne,
        alu_lt,
        alu_ge
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu,
        wb_imm,
        wb_mem,
        wb_pc_plus_4
    } wb_src_e;

    typedef enum logic [1:0] {
        pc_seq,
        pc_branch,  // pc + imm when taken
        pc_jal,
        pc_jalr     // rs1 + imm, bit 0 cleared
    } pc_src_e;

endpackage

`default_nettype wire

// ==== source/program_counter.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module program_counter (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     wb_en,
    input  wire core_pkg::pc_src_e  pc_src,
    input  wire                     branch_taken,
    input  wire [`CORE_XLEN-1:0]    imm,
    input  wire [`CORE_XLEN-1:0]    alu_result,
    output logic [`CORE_XLEN-1:0]   pc,
    output logic [`CORE_XLEN-1:0]   pc_plus_4,
    output logic                    fault
);

    logic [`CORE_XLEN-1:0] target;  // branch and jal target
    logic [`CORE_XLEN-1:0] next_pc;

    assign pc_plus_4 = pc + `CORE_XLEN'd4;
    assign target    = pc + imm;

    always_comb begin
        case (pc_src)
            core_pkg::pc_branch: next_pc = branch_taken ? target : pc_plus_4;
            core_pkg::pc_jal:    next_pc = target;
            core_pkg::pc_jalr:   next_pc = {alu_result[`CORE_XLEN-1:1], 1'b0};
            default:             next_pc = pc_plus_4;
        endcase
    end

    // no compressed instructions, so every target is word aligned
    assign fault = wb_en & (next_pc[1:0] != 2'b00);

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `CORE_RESET_PC;
        end else if (wb_en && !fault) begin
            pc <= next_pc;  // a bad target leaves pc on the faulting instruction
        end
    end

endmodule

`default_nettype wire

// ==== source/memory.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module memory (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  load_en,
    input  wire [$clog2(`CORE_MEM_WORDS)-1:0]    load_addr,  // word index
    input  wire [`CORE_XLEN-1:0]                 load_data,
    input  wire                                  fetch_en,
    input  wire                                  mem_en,
    input  wire                                  write,
    input  wire [`CORE_XLEN-1:0]                 addr,       // byte address
    input  wire [`CORE_XLEN-1:0]                 write_data,
    output logic [`CORE_XLEN-1:0]                read_data,
    output logic                                 fault
);

    localparam int addr_bits = $clog2(`CORE_MEM_WORDS);

    logic [`CORE_XLEN-1:0] words [`CORE_MEM_WORDS];
    logic [addr_bits-1:0]  index;
    logic                  access;
    logic                  misaligned;
    logic                  beyond;

    assign index      = addr[addr_bits+1:2];
    assign access     = fetch_en | mem_en;
    assign misaligned = addr[1:0] != 2'b00;
    assign beyond     = addr[`CORE_XLEN-1:2] >= (`CORE_XLEN-2)'(`CORE_MEM_WORDS);
    assign fault      = access & (misaligned | beyond);

    // load port only while the core is held in reset
    always_ff @(posedge clk) begin
        if (reset) begin
            if (load_en) begin
                words[load_addr] <= load_data;
            end
        end else if (mem_en && write && !fault) begin
            words[index] <= write_data;
        end
    end

    // read data holds until the next access and feeds the decoder as instr
    always_ff @(posedge clk) begin
        if (access && !write && !fault) begin
            read_data <= words[index];
        end
    end

    // stores only happen in the memory stage, never during a fetch
    no_store_on_fetch: assert property (
        @(posedge clk) disable iff (reset) !(write && fetch_en)
    );

endmodule

`default_nettype wire

// ==== source/instruction_decode.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module instruction_decode (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 decode_en,
    input  wire [`CORE_XLEN-1:0]                instr,
    output logic [$clog2(`CORE_REG_COUNT)-1:0]  rs1,
    output logic [$clog2(`CORE_REG_COUNT)-1:0]  rs2,
    output logic [$clog2(`CORE_REG_COUNT)-1:0]  rd,
    output logic [`CORE_XLEN-1:0]               imm,
    output core_pkg::alu_op_e                   alu_op,
    output logic                                alu_a_pc,
    output logic                                alu_b_imm,
    output logic                                reads_regs,  // valid during decode
    output logic                                uses_mem,
    output logic                                mem_write,
    output logic                                reg_write,
    output core_pkg::wb_src_e                   wb_src,
    output core_pkg::pc_src_e                   pc_src,
    output logic                                fault
);

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic                  funct7_ok;
    logic [`CORE_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [`CORE_XLEN-1:0] next_imm;
    core_pkg::alu_op_e     arith_op;
    core_pkg::alu_op_e     next_alu_op;
    core_pkg::wb_src_e     next_wb_src;
    core_pkg::pc_src_e     next_pc_src;
    logic                  next_a_pc, next_b_imm, next_uses_mem, next_mem_write;
    logic                  next_reg_write, illegal;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    // 0100000 only for sub and sra
    assign funct7_ok = (funct7 == 7'b0) ||
                       (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

    assign imm_i = {{(`CORE_XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(`CORE_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(`CORE_XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{(`CORE_XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    // shared by op and op-imm, instr[5] tells them apart
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (instr[5] && instr[30]) ? core_pkg::alu_sub : core_pkg::alu_add;
            3'b001:  arith_op = core_pkg::alu_sll;
            3'b010:  arith_op = core_pkg::alu_slt;
            3'b011:  arith_op = core_pkg::alu_sltu;
            3'b100:  arith_op = core_pkg::alu_xor;
            3'b101:  arith_op = instr[30] ? core_pkg::alu_sra : core_pkg::alu_srl;
            3'b110:  arith_op = core_pkg::alu_or;
            default: arith_op = core_pkg::alu_and;
        endcase
    end

    always_comb begin
        next_alu_op    = core_pkg::alu_add;
        next_a_pc      = 1'b0;
        next_b_imm     = 1'b1;
        reads_regs     = 1'b1;
        next_uses_mem  = 1'b0;
        next_mem_write = 1'b0;
        next_reg_write = 1'b1;
        next_wb_src    = core_pkg::wb_alu;
        next_pc_src    = core_pkg::pc_seq;
        next_imm       = imm_i;
        illegal        = 1'b0;
        case (opcode_e'(instr[6:0]))
            op_lui: begin
                reads_regs  = 1'b0;
                next_imm    = imm_u;
                next_wb_src = core_pkg::wb_imm;
            end
            op_auipc: begin
                reads_regs = 1'b0;
                next_a_pc  = 1'b1;
                next_imm   = imm_u;
            end
            op_jal: begin
                reads_regs  = 1'b0;
                next_a_pc   = 1'b1;
                next_imm    = imm_j;
                next_wb_src = core_pkg::wb_pc_plus_4;
                next_pc_src = core_pkg::pc_jal;
            end
            op_jalr: begin
                illegal     = funct3 != 3'b000;
                next_wb_src = core_pkg::wb_pc_plus_4;
                next_pc_src = core_pkg::pc_jalr;
            end
            op_branch: begin
                next_b_imm     = 1'b0;
                next_reg_write = 1'b0;
                next_imm       = imm_b;
                next_pc_src    = core_pkg::pc_branch;
                case (funct3)
                    3'b000:  next_alu_op = core_pkg::alu_eq;
                    3'b001:  next_alu_op = core_pkg::alu_ne;
                    3'b100:  next_alu_op = core_pkg::alu_lt;
                    3'b101:  next_alu_op = core_pkg::alu_ge;
                    default: illegal = 1'b1;  // unsigned branches not supported
                endcase
            end
            op_load: begin
                illegal       = funct3 != 3'b010;  // lw only
                next_uses_mem = 1'b1;
                next_wb_src   = core_pkg::wb_mem;
            end
            op_store: begin
                illegal        = funct3 != 3'b010;  // sw only
                next_uses_mem  = 1'b1;
                next_mem_write = 1'b1;
                next_reg_write = 1'b0;
                next_imm       = imm_s;
            end
            op_imm: begin
                next_alu_op = arith_op;
                illegal     = (funct3 == 3'b001 || funct3 == 3'b101) && !funct7_ok;
            end
            op_reg: begin
                next_alu_op = arith_op;
                next_b_imm  = 1'b0;
                illegal     = !funct7_ok;
            end
            default: begin
                reads_regs     = 1'b0;
                next_reg_write = 1'b0;
                illegal        = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_op    <= core_pkg::alu_add;
            alu_a_pc  <= 1'b0;
            alu_b_imm <= 1'b0;
            uses_mem  <= 1'b0;
            mem_write <= 1'b0;
            reg_write <= 1'b0;
            wb_src    <= core_pkg::wb_alu;
            pc_src    <= core_pkg::pc_seq;
            fault     <= 1'b0;
        end else if (decode_en) begin
            alu_op    <= next_alu_op;
            alu_a_pc  <= next_a_pc;
            alu_b_imm <= next_b_imm;
            uses_mem  <= next_uses_mem;
            mem_write <= next_mem_write & !illegal;
            reg_write <= next_reg_write & !illegal;
            wb_src    <= next_wb_src;
            pc_src    <= next_pc_src;
            fault     <= illegal;
        end
    end

    // instruction fields
    always_ff @(posedge clk) begin
        if (decode_en) begin
            rs1 <= instr[19:15];
            rs2 <= instr[24:20];
            rd  <= instr[11:7];
            imm <= next_imm;
        end
    end

endmodule

`default_nettype wire

// ==== source/register_file.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module register_file (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire                                 read_en,
    input  wire [$clog2(`CORE_REG_COUNT)-1:0]   rs1,
    input  wire [$clog2(`CORE_REG_COUNT)-1:0]   rs2,
    input  wire                                 wb_en,
    input  wire                                 reg_write,
    input  wire [$clog2(`CORE_REG_COUNT)-1:0]   rd,
    input  wire [`CORE_XLEN-1:0]                write_data,
    output logic [`CORE_XLEN-1:0]               rs1_data,
    output logic [`CORE_XLEN-1:0]               rs2_data
);

    logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];

    // x0 is cleared at reset and never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && reg_write && rd != '0) begin
            regs[rd] <= write_data;
        end
    end

    always_ff @(posedge clk) begin
        if (read_en) begin
            rs1_data <= regs[rs1];
            rs2_data <= regs[rs2];  // store data too
        end
    end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module alu (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     alu_en,
    input  wire core_pkg::alu_op_e  alu_op,
    input  wire [`CORE_XLEN-1:0]    a,
    input  wire [`CORE_XLEN-1:0]    b,
    output logic [`CORE_XLEN-1:0]   result,
    output logic                    branch_taken
);

    localparam int shamt_bits = $clog2(`CORE_XLEN);

    logic [`CORE_XLEN-1:0] op_result;
    logic                  taken;
    logic [shamt_bits-1:0] shamt;

    assign shamt = b[shamt_bits-1:0];

    always_comb begin
        op_result = a + b;  // compares keep the sum
        taken     = 1'b0;
        case (alu_op)
            core_pkg::alu_sub:  op_result = a - b;
            core_pkg::alu_sll:  op_result = a << shamt;
            core_pkg::alu_slt:  op_result = `CORE_XLEN'($signed(a) < $signed(b));
            core_pkg::alu_sltu: op_result = `CORE_XLEN'(a < b);
            core_pkg::alu_xor:  op_result = a ^ b;
            core_pkg::alu_srl:  op_result = a >> shamt;
            core_pkg::alu_sra:  op_result = $signed(a) >>> shamt;
            core_pkg::alu_or:   op_result = a | b;
            core_pkg::alu_and:  op_result = a & b;
            core_pkg::alu_eq:   taken = a == b;
            core_pkg::alu_ne:   taken = a != b;
            core_pkg::alu_lt:   taken = $signed(a) < $signed(b);
            core_pkg::alu_ge:   taken = $signed(a) >= $signed(b);
            default:            op_result = a + b;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            branch_taken <= 1'b0;
        end else if (alu_en) begin
            branch_taken <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_en) begin
            result <= op_result;
        end
    end

    // decoder only hands out the 14 defined operations
    op_defined: assert property (
        @(posedge clk) disable iff (reset) alu_en |-> alu_op <= core_pkg::alu_ge
    );

endmodule

`default_nettype wire

// ==== source/core.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module core (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire                                  load_en,
    input  wire [$clog2(`CORE_MEM_WORDS)-1:0]    load_addr,
    input  wire [`CORE_XLEN-1:0]                 load_data,
    output logic                                 fault,
    output logic                                 retire,
    output logic [`CORE_XLEN-1:0]                pc,
    output logic                                 rd_write,
    output logic [$clog2(`CORE_REG_COUNT)-1:0]   rd_addr,
    output logic [`CORE_XLEN-1:0]                rd_data
);

    localparam int reg_bits = $clog2(`CORE_REG_COUNT);

    core_pkg::stage_e      stage;
    core_pkg::stage_e      next_stage;
    core_pkg::alu_op_e     alu_op;
    core_pkg::wb_src_e     wb_src;
    core_pkg::pc_src_e     pc_src;
    logic                  fetch_en, decode_en, read_en, alu_en, mem_en, wb_en;
    logic                  pc_fault, mem_fault, decode_fault, halt;
    logic                  reads_regs, uses_mem, mem_write, reg_write;
    logic                  alu_a_pc, alu_b_imm, branch_taken, mem_sel;
    logic [reg_bits-1:0]   rs1, rs2, rd;
    logic [`CORE_XLEN-1:0] pc_plus_4, imm, read_data, rs1_data, rs2_data;
    logic [`CORE_XLEN-1:0] alu_a, alu_b, alu_result, mem_addr, wb_data;

    // stage sequencer with the read and memory skips
    always_comb begin
        case (stage)
            core_pkg::stage_idle:    next_stage = core_pkg::stage_fetch;
            core_pkg::stage_fetch:   next_stage = core_pkg::stage_decode;
            core_pkg::stage_decode:  next_stage = reads_regs ? core_pkg::stage_read
                                                             : core_pkg::stage_execute;
            core_pkg::stage_read:    next_stage = core_pkg::stage_execute;
            core_pkg::stage_execute: next_stage = uses_mem ? core_pkg::stage_memory
                                                           : core_pkg::stage_write_back;
            core_pkg::stage_memory:  next_stage = core_pkg::stage_write_back;
            default:                 next_stage = core_pkg::stage_fetch;
        endcase
    end

    assign halt = fault | pc_fault | mem_fault | decode_fault;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= core_pkg::stage_idle;
        end else if (!halt) begin
            stage <= next_stage;
        end
    end

    // sticky, only reset clears it
    always_ff @(posedge clk) begin
        if (reset) begin
            fault <= 1'b0;
        end else if (pc_fault || mem_fault || decode_fault) begin
            fault <= 1'b1;
        end
    end

    assign fetch_en  = (stage == core_pkg::stage_fetch) & ~fault;
    assign decode_en = (stage == core_pkg::stage_decode) & ~fault;
    assign read_en   = (stage == core_pkg::stage_read) & ~fault;
    assign alu_en    = (stage == core_pkg::stage_execute) & ~fault;
    assign mem_en    = (stage == core_pkg::stage_memory) & ~fault;
    assign wb_en     = (stage == core_pkg::stage_write_back) & ~fault;

    assign mem_sel  = stage == core_pkg::stage_memory;  // pc everywhere else
    assign mem_addr = mem_sel ? alu_result : pc;

    assign alu_a = alu_a_pc ? pc : rs1_data;
    assign alu_b = alu_b_imm ? imm : rs2_data;

    always_comb begin
        case (wb_src)
            core_pkg::wb_imm:       wb_data = imm;
            core_pkg::wb_mem:       wb_data = read_data;
            core_pkg::wb_pc_plus_4: wb_data = pc_plus_4;
            default:                wb_data = alu_result;
        endcase
    end

    assign retire   = wb_en;
    assign rd_write = wb_en & reg_write & (rd != '0);
    assign rd_addr  = rd;
    assign rd_data  = wb_data;

    program_counter u_program_counter (
        .clk, .reset, .wb_en, .pc_src, .branch_taken, .imm, .alu_result,
        .pc, .pc_plus_4, .fault(pc_fault)
    );

    memory u_memory (
        .clk, .reset, .load_en, .load_addr, .load_data, .fetch_en, .mem_en,
        .write(mem_sel & mem_write), .addr(mem_addr), .write_data(rs2_data),
        .read_data, .fault(mem_fault)
    );

    instruction_decode u_instruction_decode (
        .clk, .reset, .decode_en, .instr(read_data), .rs1, .rs2, .rd, .imm, .alu_op,
        .alu_a_pc, .alu_b_imm, .reads_regs, .uses_mem, .mem_write, .reg_write,
        .wb_src, .pc_src, .fault(decode_fault)
    );

    register_file u_register_file (
        .clk, .reset, .read_en, .rs1, .rs2, .wb_en, .reg_write, .rd,
        .write_data(wb_data), .rs1_data, .rs2_data
    );

    alu u_alu (
        .clk, .reset, .alu_en, .alu_op, .a(alu_a), .b(alu_b),
        .result(alu_result), .branch_taken
    );

    stage_legal: assert property (
        @(posedge clk) disable iff (reset) $onehot0(stage)
    );

    // a fault freezes the sequencer until reset
    stage_frozen: assert property (
        @(posedge clk) disable iff (reset) fault |=> $stable(stage)
    );

endmodule

`default_nettype wire

// ==== bench/core_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "core_settings.svh"

module core_tb;

    localparam int rows = 32;
    localparam int addr_bits = $clog2(`CORE_MEM_WORDS);
    localparam int reg_bits = $clog2(`CORE_REG_COUNT);
    localparam int timeout_cycles = rows * 8 + rows + 64;  // run, load and quiet time

    localparam int kind_write = 0;  // retires and writes rd
    localparam int kind_none  = 1;  // retires without a register write
    localparam int kind_skip  = 2;  // jumped over, never retires
    localparam int kind_fault = 3;  // raises fault instead of retiring

    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_jalr  = 7'b1100111;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;

    logic                  clk;
    logic                  reset;
    logic                  load_en;
    logic [addr_bits-1:0]  load_addr;
    logic [`CORE_XLEN-1:0] load_data;
    logic                  fault;
    logic                  retire;
    logic                  rd_write;
    logic [`CORE_XLEN-1:0] pc;
    logic [reg_bits-1:0]   rd_addr;
    logic [`CORE_XLEN-1:0] rd_data;

    // program and expected write back, one row per instruction word
    logic [31:0]           prog [rows];
    int                    kinds [rows];
    logic [reg_bits-1:0]   exp_rd [rows];
    logic [`CORE_XLEN-1:0] exp_val [rows];

    int          row_count;
    int          retire_count;
    int          expected_retires;
    int          quiet_start;
    int          rows_checked;
    int          errors;
    int          seed;
    logic [31:0] rnd_hi, rnd_lo, v1, v2;

    core u_core (
        .clk, .reset, .load_en, .load_addr, .load_data,
        .fault, .retire, .pc, .rd_write, .rd_addr, .rd_data
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (reset) begin
            retire_count <= 0;
        end else if (retire) begin
            retire_count <= retire_count + 1;
        end
    end

    // instruction formats from the base ISA
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] row_address(input int row);
        return 32'(`CORE_RESET_PC + 4 * row);
    endfunction

    task automatic add_row(input logic [31:0] instr, input int kind,
                           input logic [reg_bits-1:0] rd, input logic [`CORE_XLEN-1:0] value);
        prog[row_count]    = instr;
        kinds[row_count]   = kind;
        exp_rd[row_count]  = rd;
        exp_val[row_count] = value;
        row_count++;
    endtask

    task automatic build_program();
        seed   = 32'hbbf2;
        rnd_hi = $random(seed);
        rnd_lo = $random(seed);
        v1 = {rnd_hi[31:12], 12'b0} + {{20{rnd_lo[11]}}, rnd_lo[11:0]};
        v2 = {{20{rnd_lo[23]}}, rnd_lo[23:12]};
        row_count = 0;
        add_row(u_type(rnd_hi[31:12], 5'd1, op_lui), kind_write, 5'd1, {rnd_hi[31:12], 12'b0});
        add_row(i_type(rnd_lo[11:0], 5'd1, 3'b000, 5'd1, op_imm), kind_write, 5'd1, v1);
        add_row(i_type(rnd_lo[23:12], 5'd0, 3'b000, 5'd2, op_imm), kind_write, 5'd2, v2);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), kind_write, 5'd3, v1 + v2);
        add_row(r_type(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), kind_write, 5'd4, v1 - v2);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd5), kind_write, 5'd5, v1 ^ v2);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd6), kind_write, 5'd6, v1 | v2);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b111, 5'd7), kind_write, 5'd7, v1 & v2);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd8), kind_write, 5'd8, v1 << v2[4:0]);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b101, 5'd9), kind_write, 5'd9, v1 >> v2[4:0]);
        add_row(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd10), kind_write, 5'd10,
                $signed(v1) >>> v2[4:0]);
        add_row(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd11), kind_write, 5'd11,
                {31'b0, $signed(v1) < $signed(v2)});
        add_row(i_type({7'h20, 5'd7}, 5'd1, 3'b101, 5'd12, op_imm), kind_write, 5'd12,
                $signed(v1) >>> 7);
        add_row(i_type(12'd5, 5'd0, 3'b000, 5'd0, op_imm), kind_none, 5'd0, 32'd0);  // x0 target
        add_row(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd13), kind_write, 5'd13, 32'd0);
        add_row(i_type(12'd512, 5'd0, 3'b000, 5'd14, op_imm), kind_write, 5'd14, 32'd512);
        add_row(s_type(12'd0, 5'd3, 5'd14), kind_none, 5'd0, 32'd0);
        add_row(i_type(12'd0, 5'd14, 3'b010, 5'd15, op_load), kind_write, 5'd15, v1 + v2);
        add_row(b_type(13'd8, 5'd1, 5'd1, 3'b000), kind_none, 5'd0, 32'd0);  // beq taken
        add_row(i_type(12'd1, 5'd0, 3'b000, 5'd16, op_imm), kind_skip, 5'd16, 32'd1);
        add_row(b_type(13'd8, 5'd1, 5'd1, 3'b001), kind_none, 5'd0, 32'd0);  // bne falls through
        add_row(i_type(12'd2, 5'd0, 3'b000, 5'd17, op_imm), kind_write, 5'd17, 32'd2);
        add_row(b_type(13'd8, 5'd17, 5'd0, 3'b100), kind_none, 5'd0, 32'd0);  // 0 < 2
        add_row(i_type(12'd3, 5'd0, 3'b000, 5'd16, op_imm), kind_skip, 5'd16, 32'd3);
        add_row(j_type(21'd8, 5'd18), kind_write, 5'd18, row_address(24) + 32'd4);
        add_row(i_type(12'd4, 5'd0, 3'b000, 5'd16, op_imm), kind_skip, 5'd16, 32'd4);
        add_row(u_type(20'd1, 5'd19, op_auipc), kind_write, 5'd19, row_address(26) + 32'd4096);
        add_row(i_type(12'd120, 5'd0, 3'b000, 5'd20, op_imm), kind_write, 5'd20, 32'd120);
        add_row(i_type(12'd0, 5'd20, 3'b000, 5'd21, op_jalr), kind_write, 5'd21,
                row_address(28) + 32'd4);
        add_row(i_type(12'd5, 5'd0, 3'b000, 5'd16, op_imm), kind_skip, 5'd16, 32'd5);
        add_row(u_type(20'd1, 5'd24, op_lui), kind_write, 5'd24, 32'd4096);
        add_row(i_type(12'd0, 5'd24, 3'b010, 5'd25, op_load), kind_fault, 5'd25, 32'd0);
    endtask

    initial begin
        reset        = 1'b1;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        errors       = 0;
        rows_checked = 0;
        build_program();
        expected_retires = 0;
        for (int i = 0; i < rows; i++) begin
            if (kinds[i] == kind_write || kinds[i] == kind_none) begin
                expected_retires++;
            end
        end

        // program goes in while reset is high and reset holds 3 more cycles after it
        for (int i = 0; i < rows; i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= addr_bits'((`CORE_RESET_PC >> 2) + i);
            load_data <= prog[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        for (int i = 0; i < rows; i++) begin
            if (kinds[i] == kind_skip) begin
                continue;
            end
            rows_checked++;
            if (kinds[i] == kind_fault) begin
                while (!fault) @(negedge clk);
                if (pc !== row_address(i)) begin
                    errors++;
                    $display("** Error at %0t: pc is %h, expected %h", $time, pc, row_address(i));
                end
                quiet_start = retire_count;
                repeat (20) @(negedge clk);
                if (retire_count != quiet_start) begin
                    errors++;
                    $display("a retire pulse appeared at %0t after fault was raised", $time);
                end
            end else begin
                @(negedge clk);
                while (!retire) @(negedge clk);
                if (fault !== 1'b0) begin
                    errors++;
                    $display("** Error at %0t: fault is %b, expected 0", $time, fault);
                end
                if (pc !== row_address(i)) begin
                    errors++;
                    $display("** Error at %0t: pc is %h, expected %h", $time, pc, row_address(i));
                end
                if (rd_write !== (kinds[i] == kind_write)) begin
                    errors++;
                    $display("** Error at %0t: rd_write is %b, expected %b (row %0d)",
                             $time, rd_write, kinds[i] == kind_write, i);
                end else if (rd_write) begin
                    if (rd_addr !== exp_rd[i]) begin
                        errors++;
                        $display("** Error at %0t: rd_addr is %0d, expected %0d (row %0d)",
                                 $time, rd_addr, exp_rd[i], i);
                    end
                    if (rd_data !== exp_val[i]) begin
                        errors++;
                        $display("** Error at %0t: rd_data is %h, expected %h (row %0d)",
                                 $time, rd_data, exp_val[i], i);
                    end
                end
            end
        end

        if (retire_count != expected_retires) begin
            errors++;
            $display("** Error at %0t: retire count is %0d, expected %0d",
                     $time, retire_count, expected_retires);
        end
        $display("rows checked %0d, retire pulses %0d, errors %0d",
                 rows_checked, retire_count, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // watchdog sized from the table length
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout, the program did not finish within %0d cycles", timeout_cycles);
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/core_pkg.sv
source/program_counter.sv
source/memory.sv
source/instruction_decode.sv
source/register_file.sv
source/alu.sv
source/core.sv
bench/core_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = core_tb
FILE_LIST = sources.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)

# the run passes only when the testbench prints the pass message
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)
